//--- include/roulette_config.svh
//-------------------------------------------------
// Game constants for the roulette round controller
// Included by the package and by every block that
// decodes keys or checks bet limits
//-------------------------------------------------
`ifndef ROULETTE_CONFIG_SVH
`define ROULETTE_CONFIG_SVH

//-------------------------------------------------
// Keypad codes
//-------------------------------------------------
// Digits 0..9 use their own value
`define KEY_DIGIT_MAX 9
// Confirm key '*'
`define KEY_STAR 10
// Clear key '#'
`define KEY_HASH 11

//-------------------------------------------------
// Bet limits
//-------------------------------------------------
// Largest number of picks in one round
`define MAX_PICKS 4
// Pick numbers run from 1 up to this value
`define PICK_MAX 8

//-------------------------------------------------
// Money
//-------------------------------------------------
`define MONEY_W 16
// Balance at or above this value clears the game
`define CLEAR_MONEY 10000

`endif

//--- logic/roulette_pkg.sv
//-------------------------------------------------
// Shared types of the roulette round controller
// Import with a wildcard in the module header
//-------------------------------------------------
`include "roulette_config.svh"

package roulette_pkg;

    //-------------------------------------------------
    // Value types
    //-------------------------------------------------
    // Keypad code, digits plus '*' and '#'
    typedef logic [3:0] key_t;

    // Money amount, decimal entry wraps at this width
    typedef logic [`MONEY_W-1:0] money_t;

    // Bet count, or number of picks entered so far
    typedef logic [2:0] count_t;

    // One pick number
    typedef logic [3:0] pick_t;

    //-------------------------------------------------
    // Round states
    //-------------------------------------------------
    // Codes are fixed, the display side reads them raw
    typedef enum logic [3:0] {
        IDLE         = 4'd0,
        BET_MONEY    = 4'd1,
        BET_SELECT   = 4'd2,
        NUMBER_INPUT = 4'd3,
        START_SPIN   = 4'd4,
        SLOW_DOWN    = 4'd5,
        STOP_RESULT  = 4'd6,
        WIN_DISPLAY  = 4'd7,
        LOSE_DISPLAY = 4'd8,
        UPDATE_MONEY = 4'd9,
        CHECK_MONEY  = 4'd10,
        NEXT_STAGE   = 4'd11,
        GAME_OVER    = 4'd12,
        GAME_CLEAR   = 4'd13
    } game_state_t;

endpackage

//--- logic/bet_amount_entry.sv
//-------------------------------------------------
// Bet amount entry, active only in BET_MONEY
// Builds the amount from decimal keys and decides
// on '*' whether it can be confirmed
//-------------------------------------------------
`include "roulette_config.svh"

module bet_amount_entry import roulette_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        key_valid,
    input  key_t        key_value,
    input  game_state_t state,
    input  money_t      current_money,
    input  logic        reset_round,
    output money_t      bet_amount,
    output logic        amount_accept,
    output logic        amount_clear
);

    //-------------------------------------------------
    // Key decode
    //-------------------------------------------------
    logic   active;
    logic   key_digit;
    logic   key_star;
    logic   key_hash;
    logic   amount_legal;
    money_t amount_next;

    // Round restart wins over any key in the same cycle
    assign active    = (state == BET_MONEY) && key_valid && !reset_round;

    assign key_digit = active && (key_value <= key_t'(`KEY_DIGIT_MAX));
    assign key_star  = active && (key_value == key_t'(`KEY_STAR));
    assign key_hash  = active && (key_value == key_t'(`KEY_HASH));

    //-------------------------------------------------
    // Confirm decision
    //-------------------------------------------------
    // Nonzero and covered by the current balance
    assign amount_legal  = (bet_amount != '0) && (bet_amount <= current_money);

    assign amount_accept = key_star && amount_legal;

    // Hash always clears, a star clears only when refused
    assign amount_clear  = key_hash || (key_star && !amount_legal);

    //-------------------------------------------------
    // Decimal accumulator
    //-------------------------------------------------
    // Ten times the amount as 8x + 2x, plus the new digit
    // Result wraps at the money width
    assign amount_next = (bet_amount << 3) + (bet_amount << 1) + money_t'(key_value);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bet_amount <= '0;
        end else if (reset_round) begin
            // New round starts from an empty amount
            bet_amount <= '0;
        end else if (amount_clear) begin
            bet_amount <= '0;
        end else if (key_digit) begin
            bet_amount <= amount_next;
        end
    end

endmodule

//--- logic/pick_entry.sv
//-------------------------------------------------
// Bet count selection and pick number entry
// Active in BET_SELECT and NUMBER_INPUT, holds the
// picks in entry order for the hit check
//-------------------------------------------------
`include "roulette_config.svh"

module pick_entry import roulette_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        key_valid,
    input  key_t        key_value,
    input  game_state_t state,
    input  logic        reset_round,
    output count_t      bet_count,
    output pick_t       pick0,
    output pick_t       pick1,
    output pick_t       pick2,
    output pick_t       pick3,
    output logic        count_accept,
    output logic        picks_accept,
    output logic        pick_clear
);

    //-------------------------------------------------
    // Key decode per state
    //-------------------------------------------------
    logic   key_live;
    logic   sel_active;
    logic   num_active;
    logic   key_star;
    logic   key_hash;
    logic   count_key;
    logic   pick_key;
    logic   count_legal;
    logic   picks_legal;
    logic   count_clear;
    logic   picks_clear;
    logic   pick_write;
    count_t picks_entered;

    // Keys are dropped in the restart cycle
    assign key_live   = key_valid && !reset_round;
    assign sel_active = key_live && (state == BET_SELECT);
    assign num_active = key_live && (state == NUMBER_INPUT);

    assign key_star   = (key_value == key_t'(`KEY_STAR));
    assign key_hash   = (key_value == key_t'(`KEY_HASH));

    // Count keys 1..MAX_PICKS, pick keys 1..PICK_MAX
    assign count_key  = (key_value >= key_t'(1)) && (key_value <= key_t'(`MAX_PICKS));
    assign pick_key   = (key_value >= key_t'(1)) && (key_value <= key_t'(`PICK_MAX));

    //-------------------------------------------------
    // Confirm decisions
    //-------------------------------------------------
    assign count_legal = (bet_count >= count_t'(1)) && (bet_count <= count_t'(`MAX_PICKS));

    // All requested picks entered, and a count was chosen
    assign picks_legal = (picks_entered == bet_count) && (bet_count != '0);

    assign count_accept = sel_active && key_star && count_legal;
    assign picks_accept = num_active && key_star && picks_legal;

    assign count_clear  = sel_active && (key_hash || (key_star && !count_legal));
    assign picks_clear  = num_active && (key_hash || (key_star && !picks_legal));

    assign pick_clear   = count_clear || picks_clear;

    // Extra picks past the bet count are ignored
    assign pick_write   = num_active && pick_key && (picks_entered < bet_count);

    //-------------------------------------------------
    // Bet count register
    //-------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bet_count <= '0;
        end else if (reset_round || count_clear) begin
            bet_count <= '0;
        end else if (sel_active && count_key) begin
            // Last valid count key wins
            bet_count <= count_t'(key_value);
        end
    end

    //-------------------------------------------------
    // Pick slots, filled in order
    //-------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            picks_entered <= '0;
            pick0         <= '0;
            pick1         <= '0;
            pick2         <= '0;
            pick3         <= '0;
        end else if (reset_round || picks_clear) begin
            picks_entered <= '0;
            pick0         <= '0;
            pick1         <= '0;
            pick2         <= '0;
            pick3         <= '0;
        end else if (pick_write) begin
            // Next free slot is given by the entry count
            case (picks_entered)
                count_t'(0): pick0 <= pick_t'(key_value);
                count_t'(1): pick1 <= pick_t'(key_value);
                count_t'(2): pick2 <= pick_t'(key_value);
                default:     pick3 <= pick_t'(key_value);
            endcase
            picks_entered <= picks_entered + count_t'(1);
        end
    end

endmodule

//--- logic/game_fsm.sv
//-------------------------------------------------
// Round state machine of the roulette game
// Steps on accept strobes from the entry blocks and
// on roulette and money flags, and owns all pulses
//-------------------------------------------------
`include "roulette_config.svh"

module game_fsm import roulette_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        key_valid,
    input  key_t        key_value,
    input  logic        amount_accept,
    input  logic        count_accept,
    input  logic        picks_accept,
    input  logic        amount_clear,
    input  logic        pick_clear,
    input  logic        spin_done,
    input  logic        win_flag,
    input  logic        money_zero,
    input  logic        money_10000,
    output game_state_t state,
    output logic        clear_input,
    output logic        start_spin,
    output logic        update_money_req,
    output logic        reset_round
);

    game_state_t state_next;
    logic        key_star;
    logic        round_restart;

    assign key_star = key_valid && (key_value == key_t'(`KEY_STAR));

    //-------------------------------------------------
    // Restart decode
    //-------------------------------------------------
    // A star in a waiting state starts a fresh round
    always_comb begin
        case (state)
            IDLE,
            NEXT_STAGE,
            GAME_OVER,
            GAME_CLEAR: round_restart = key_star;
            default:    round_restart = 1'b0;
        endcase
    end

    //-------------------------------------------------
    // Next state
    //-------------------------------------------------
    always_comb begin
        state_next = state;

        case (state)
            IDLE: begin
                if (key_star) begin
                    state_next = BET_MONEY;
                end
            end

            // Entry states move only on a legal confirm
            BET_MONEY: begin
                if (amount_accept) begin
                    state_next = BET_SELECT;
                end
            end

            BET_SELECT: begin
                if (count_accept) begin
                    state_next = NUMBER_INPUT;
                end
            end

            NUMBER_INPUT: begin
                if (picks_accept) begin
                    state_next = START_SPIN;
                end
            end

            START_SPIN: state_next = SLOW_DOWN;

            // Roulette decides how long the wheel runs
            SLOW_DOWN: begin
                if (spin_done) begin
                    state_next = STOP_RESULT;
                end
            end

            // Hit check result is valid here
            STOP_RESULT: begin
                if (win_flag) begin
                    state_next = WIN_DISPLAY;
                end else begin
                    state_next = LOSE_DISPLAY;
                end
            end

            WIN_DISPLAY:  state_next = UPDATE_MONEY;
            LOSE_DISPLAY: state_next = UPDATE_MONEY;
            UPDATE_MONEY: state_next = CHECK_MONEY;

            // Empty balance beats the clear threshold
            CHECK_MONEY: begin
                if (money_zero) begin
                    state_next = GAME_OVER;
                end else if (money_10000) begin
                    state_next = GAME_CLEAR;
                end else begin
                    state_next = NEXT_STAGE;
                end
            end

            NEXT_STAGE: begin
                if (key_star) begin
                    state_next = BET_MONEY;
                end
            end

            GAME_OVER,
            GAME_CLEAR: begin
                if (key_star) begin
                    state_next = IDLE;
                end
            end

            // Unused codes fall back to the start
            default: state_next = IDLE;
        endcase
    end

    //-------------------------------------------------
    // State and pulse registers
    //-------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state            <= IDLE;
            clear_input      <= 1'b0;
            start_spin       <= 1'b0;
            update_money_req <= 1'b0;
            reset_round      <= 1'b0;
        end else begin
            state            <= state_next;
            // Keypad buffer clear after any refused or cleared entry
            clear_input      <= amount_clear || pick_clear;
            // Wheel start lines up with the first SLOW_DOWN cycle
            start_spin       <= (state == START_SPIN);
            // High for exactly the UPDATE_MONEY cycle
            update_money_req <= (state_next == UPDATE_MONEY);
            reset_round      <= round_restart;
        end
    end

endmodule

//--- logic/roulette_ctrl_top.sv
//-------------------------------------------------
// Top of the roulette round controller
// Joins the state machine with the two entry blocks
//-------------------------------------------------
module roulette_ctrl_top import roulette_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        key_valid,
    input  key_t        key_value,
    input  logic        spin_done,
    input  logic        win_flag,
    input  logic        money_zero,
    input  logic        money_10000,
    input  money_t      current_money,
    output game_state_t state,
    output money_t      bet_amount,
    output count_t      bet_count,
    output pick_t       pick0,
    output pick_t       pick1,
    output pick_t       pick2,
    output pick_t       pick3,
    output logic        clear_input,
    output logic        start_spin,
    output logic        update_money_req,
    output logic        reset_round
);

    // Confirm and clear strobes from the entry blocks
    logic amount_accept;
    logic amount_clear;
    logic count_accept;
    logic picks_accept;
    logic pick_clear;

    //-------------------------------------------------
    // Round sequencing
    //-------------------------------------------------
    game_fsm i_game_fsm (
        .clk              (clk),
        .rst              (rst),
        .key_valid        (key_valid),
        .key_value        (key_value),
        .amount_accept    (amount_accept),
        .count_accept     (count_accept),
        .picks_accept     (picks_accept),
        .amount_clear     (amount_clear),
        .pick_clear       (pick_clear),
        .spin_done        (spin_done),
        .win_flag         (win_flag),
        .money_zero       (money_zero),
        .money_10000      (money_10000),
        .state            (state),
        .clear_input      (clear_input),
        .start_spin       (start_spin),
        .update_money_req (update_money_req),
        .reset_round      (reset_round)
    );

    //-------------------------------------------------
    // Bet entry
    //-------------------------------------------------
    bet_amount_entry i_bet_amount_entry (
        .clk           (clk),
        .rst           (rst),
        .key_valid     (key_valid),
        .key_value     (key_value),
        .state         (state),
        .current_money (current_money),
        .reset_round   (reset_round),
        .bet_amount    (bet_amount),
        .amount_accept (amount_accept),
        .amount_clear  (amount_clear)
    );

    pick_entry i_pick_entry (
        .clk          (clk),
        .rst          (rst),
        .key_valid    (key_valid),
        .key_value    (key_value),
        .state        (state),
        .reset_round  (reset_round),
        .bet_count    (bet_count),
        .pick0        (pick0),
        .pick1        (pick1),
        .pick2        (pick2),
        .pick3        (pick3),
        .count_accept (count_accept),
        .picks_accept (picks_accept),
        .pick_clear   (pick_clear)
    );

endmodule

//--- bench/tb_roulette_ctrl.sv
//-------------------------------------------------
// Testbench for the roulette round controller
// Plays full rounds from the keypad against models
// of the wheel, hit check and money flags
//-------------------------------------------------
`include "roulette_config.svh"

module tb_roulette_ctrl import roulette_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam key_t STAR = key_t'(`KEY_STAR);
    localparam key_t HASH = key_t'(`KEY_HASH);

    // Limit is four times a worst case round of about 150 cycles
    localparam int ROUNDS       = 32;
    localparam int ROUND_CYCLES = 150;
    localparam int CYCLE_LIMIT  = 4 * ROUNDS * ROUND_CYCLES;

    //-------------------------------------------------
    // DUT ports
    //-------------------------------------------------
    logic        clk;
    logic        rst;
    logic        key_valid;
    key_t        key_value;
    logic        spin_done;
    logic        win_flag;
    logic        money_zero;
    logic        money_10000;
    money_t      current_money;
    game_state_t state;
    money_t      bet_amount;
    count_t      bet_count;
    pick_t       pick0;
    pick_t       pick1;
    pick_t       pick2;
    pick_t       pick3;
    logic        clear_input;
    logic        start_spin;
    logic        update_money_req;
    logic        reset_round;

    // Expected values updated after each sampling edge
    game_state_t exp_state;
    money_t      exp_amount;
    count_t      exp_count;
    count_t      exp_entered;
    pick_t       exp_pick [4];
    logic        exp_clear;
    logic        exp_restart;
    logic        exp_start;
    logic        exp_update;
    logic [31:0] seed;
    int          cycle_count = 0;
    logic [15:0] picks_all;
    logic [15:0] exp_picks_all;

    assign picks_all     = {pick0, pick1, pick2, pick3};
    assign exp_picks_all = {exp_pick[0], exp_pick[1], exp_pick[2], exp_pick[3]};

    roulette_ctrl_top i_dut (.*);

    always #4 clk = ~clk;

    //-------------------------------------------------
    // Failure reporting and run limit
    //-------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        fail_run($sformatf("error %s: got 0x%0h, expected 0x%0h", name, got, expected));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            fail_run("timeout: the run did not finish within the cycle limit");
        end
    end

    //-------------------------------------------------
    // Checks against the model
    //-------------------------------------------------
    state_match: assert property (@(posedge clk) disable iff (rst) state == exp_state)
        else report_mismatch("state", 32'($sampled(state)), 32'($sampled(exp_state)));
    amount_match: assert property (@(posedge clk) disable iff (rst) bet_amount == exp_amount)
        else report_mismatch("bet_amount", 32'($sampled(bet_amount)), 32'($sampled(exp_amount)));
    count_match: assert property (@(posedge clk) disable iff (rst) bet_count == exp_count)
        else report_mismatch("bet_count", 32'($sampled(bet_count)), 32'($sampled(exp_count)));
    picks_match: assert property (@(posedge clk) disable iff (rst) picks_all == exp_picks_all)
        else report_mismatch("pick0..pick3", 32'($sampled(picks_all)),
                             32'($sampled(exp_picks_all)));
    clear_match: assert property (@(posedge clk) disable iff (rst) clear_input == exp_clear)
        else report_mismatch("clear_input", 32'($sampled(clear_input)), 32'($sampled(exp_clear)));
    restart_match: assert property (@(posedge clk) disable iff (rst) reset_round == exp_restart)
        else report_mismatch("reset_round", 32'($sampled(reset_round)),
                             32'($sampled(exp_restart)));
    spin_match: assert property (@(posedge clk) disable iff (rst) start_spin == exp_start)
        else report_mismatch("start_spin", 32'($sampled(start_spin)), 32'($sampled(exp_start)));
    update_match: assert property (@(posedge clk) disable iff (rst) update_money_req == exp_update)
        else report_mismatch("update_money_req", 32'($sampled(update_money_req)),
                             32'($sampled(exp_update)));

    //-------------------------------------------------
    // Random source
    //-------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Value in 0 .. range-1
    function automatic int unsigned next_random(input int unsigned range);
        seed = xorshift32(seed);
        return seed % range;
    endfunction

    //-------------------------------------------------
    // Round model called once per clock edge
    //-------------------------------------------------
    task automatic clear_picks();
        exp_entered = '0;
        for (int i = 0; i < 4; i++) begin
            exp_pick[i] = '0;
        end
    endtask

    task automatic edge_update(input logic key_seen, input key_t k);
        game_state_t prev;
        prev = exp_state;
        // Entry registers empty one edge after the restart star
        if (exp_restart) begin
            exp_amount = '0;
            exp_count  = '0;
            clear_picks();
        end
        exp_restart = 1'b0;
        exp_clear   = 1'b0;
        exp_start   = 1'b0;
        exp_update  = 1'b0;
        case (prev)
            IDLE, NEXT_STAGE: begin
                if (key_seen && k == STAR) begin
                    exp_restart = 1'b1;
                    exp_state   = BET_MONEY;
                end
            end
            GAME_OVER, GAME_CLEAR: begin
                if (key_seen && k == STAR) begin
                    exp_restart = 1'b1;
                    exp_state   = IDLE;
                end
            end
            BET_MONEY: begin
                if (key_seen && k <= key_t'(`KEY_DIGIT_MAX)) begin
                    // Decimal shift wrapping at the money width
                    exp_amount = money_t'(32'(exp_amount) * 10 + 32'(k));
                end else if (key_seen && k == STAR && exp_amount != '0
                             && exp_amount <= current_money) begin
                    exp_state = BET_SELECT;
                end else if (key_seen && (k == STAR || k == HASH)) begin
                    exp_amount = '0;
                    exp_clear  = 1'b1;
                end
            end
            BET_SELECT: begin
                if (key_seen && k >= key_t'(1) && k <= key_t'(`MAX_PICKS)) begin
                    exp_count = count_t'(k);
                end else if (key_seen && k == STAR && exp_count >= count_t'(1)
                             && exp_count <= count_t'(`MAX_PICKS)) begin
                    exp_state = NUMBER_INPUT;
                end else if (key_seen && (k == STAR || k == HASH)) begin
                    exp_count = '0;
                    exp_clear = 1'b1;
                end
            end
            NUMBER_INPUT: begin
                if (key_seen && k >= key_t'(1) && k <= key_t'(`PICK_MAX)) begin
                    // Picks past the bet count are dropped
                    if (exp_entered < exp_count) begin
                        exp_pick[exp_entered[1:0]] = pick_t'(k);
                        exp_entered = exp_entered + count_t'(1);
                    end
                end else if (key_seen && k == STAR && exp_count != '0
                             && exp_entered == exp_count) begin
                    exp_state = START_SPIN;
                end else if (key_seen && (k == STAR || k == HASH)) begin
                    clear_picks();
                    exp_clear = 1'b1;
                end
            end
            START_SPIN: begin
                exp_state = SLOW_DOWN;
                exp_start = 1'b1;
            end
            SLOW_DOWN: begin
                if (spin_done) begin
                    exp_state = STOP_RESULT;
                end
            end
            STOP_RESULT: begin
                if (win_flag) begin
                    exp_state = WIN_DISPLAY;
                end else begin
                    exp_state = LOSE_DISPLAY;
                end
            end
            WIN_DISPLAY, LOSE_DISPLAY: begin
                exp_state  = UPDATE_MONEY;
                exp_update = 1'b1;
            end
            UPDATE_MONEY: exp_state = CHECK_MONEY;
            // Empty balance has priority over the clear threshold
            CHECK_MONEY: begin
                if (money_zero) begin
                    exp_state = GAME_OVER;
                end else if (money_10000) begin
                    exp_state = GAME_CLEAR;
                end else begin
                    exp_state = NEXT_STAGE;
                end
            end
            default: begin
            end
        endcase
    endtask

    //-------------------------------------------------
    // Keypad stimulus called on a falling edge
    //-------------------------------------------------
    task automatic idle_cycle();
        @(posedge clk);
        edge_update(1'b0, '0);
        @(negedge clk);
    endtask

    task automatic press(input key_t k);
        key_valid = 1'b1;
        key_value = k;
        @(posedge clk);
        edge_update(1'b1, k);
        @(negedge clk);
        key_valid = 1'b0;
        key_value = '0;
        idle_cycle();
    endtask

    // Decimal digits with the most significant first
    task automatic enter_number(input int unsigned value);
        int unsigned digits [5];
        int unsigned rest;
        int          n;
        rest = value;
        n    = 0;
        do begin
            digits[n] = rest % 10;
            rest      = rest / 10;
            n++;
        end while (rest != 0);
        for (int i = n - 1; i >= 0; i--) begin
            press(key_t'(digits[i]));
        end
    endtask

    task automatic play_round(input int unsigned round_idx);
        int unsigned n;
        int unsigned outcome;
        int unsigned spin_delay;
        // Refused amounts first and then a legal bet
        current_money = money_t'(1 + next_random(9999));
        press(HASH);
        press(STAR);
        enter_number(32'(current_money) + 1);
        press(STAR);
        repeat (6) begin
            press(key_t'(next_random(10)));
        end
        press(HASH);
        press(key_t'(12));
        enter_number(1 + next_random(32'(current_money)));
        press(STAR);
        // Count selection with a refused star and a clear
        n = 1 + next_random(`MAX_PICKS);
        press(STAR);
        press(key_t'(7));
        press(key_t'(2));
        press(HASH);
        press(key_t'(3));
        press(key_t'(n));
        press(STAR);
        // Out of range keys and then a refused short entry
        press(key_t'(9));
        press(key_t'(0));
        if (n > 1) begin
            press(key_t'(1 + next_random(`PICK_MAX)));
        end
        press(STAR);
        repeat (n) begin
            press(key_t'(1 + next_random(`PICK_MAX)));
        end
        press(key_t'(5));
        // Every money outcome appears once in the first rounds
        outcome     = (round_idx < 4) ? round_idx : next_random(4);
        win_flag    = (next_random(2) == 1);
        money_zero  = (outcome == 0) || (outcome == 2);
        money_10000 = (outcome == 1) || (outcome == 2);
        spin_delay  = 1 + next_random(20);
        press(STAR);
        // Wheel stops spin_delay cycles after start_spin
        repeat (spin_delay - 1) begin
            idle_cycle();
        end
        spin_done = 1'b1;
        idle_cycle();
        spin_done = 1'b0;
        while (!(exp_state inside {NEXT_STAGE, GAME_OVER, GAME_CLEAR})) begin
            idle_cycle();
        end
        // Back to betting through IDLE when the game has ended
        press(STAR);
        if (exp_state == IDLE) begin
            press(STAR);
        end
    endtask

    //-------------------------------------------------
    // Main sequence
    //-------------------------------------------------
    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        key_valid     = 1'b0;
        key_value     = '0;
        spin_done     = 1'b0;
        win_flag      = 1'b0;
        money_zero    = 1'b0;
        money_10000   = 1'b0;
        current_money = '0;
        seed          = 32'd32285;
        exp_state     = IDLE;
        exp_amount    = '0;
        exp_count     = '0;
        exp_clear     = 1'b0;
        exp_restart   = 1'b0;
        exp_start     = 1'b0;
        exp_update    = 1'b0;
        clear_picks();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // A digit in IDLE is ignored and a star opens the game
        press(key_t'(5));
        press(STAR);
        for (int r = 0; r < ROUNDS; r++) begin
            play_round(r);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
logic/roulette_pkg.sv
logic/bet_amount_entry.sv
logic/pick_entry.sv
logic/game_fsm.sv
logic/roulette_ctrl_top.sv
bench/tb_roulette_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build the roulette controller testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module tb_roulette_ctrl -o tb_sim

# A stop on $fatal exits nonzero, the log is searched below
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
